// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only when the pass line shows up
verilator --binary --timing -f verilog.f --top-module tb_cart_top -Mdir obj_dir \
	&& ./obj_dir/Vtb_cart_top | grep "Done: no errors" \
	|| { echo "Simulation failed"; exit 1; }

// File: source/bus_decode.sv
`timescale 1ns/1ps

module bus_decode (
	input  logic                                mclk,
	input  logic                                rst_n,
	input  snes_cart_pkg::map_mode_t            map_mode,
	input  logic                                msu_enable,
	input  logic [snes_cart_pkg::CPU_AW-1:0]    ca,
	input  logic                                cpurd_n,
	input  logic                                cpuwr_n,
	input  logic [snes_cart_pkg::DATA_W-1:0]    cpu_dout,
	output logic [snes_cart_pkg::CPU_AW-1:0]    s1_ca,
	output snes_cart_pkg::region_t              s1_region,
	output logic                                s1_rd,
	output logic                                s1_wr,
	output logic [snes_cart_pkg::DATA_W-1:0]    s1_wdata
);

	logic [7:0]             bank;
	logic                   idle;
	snes_cart_pkg::region_t region;

	assign bank = ca[23:16];
	assign idle = cpurd_n && cpuwr_n;

	// Priority decode, first match wins
	always_comb begin
		region = snes_cart_pkg::REG_NONE;
		if (idle) begin
			region = snes_cart_pkg::REG_NONE;
		end else if (bank == 8'h7e || bank == 8'h7f) begin
			region = snes_cart_pkg::REG_WRAM;
		end else if (msu_enable && !ca[22] && ca[15:3] == snes_cart_pkg::MSU_BASE[15:3]) begin
			region = snes_cart_pkg::REG_MSU;
		end else if (map_mode == snes_cart_pkg::MAP_LOROM) begin
			if (&ca[22:20] && !ca[15]) begin
				region = snes_cart_pkg::REG_BSRAM;
			end else if (ca[15]) begin
				region = snes_cart_pkg::REG_ROM;
			end
		end else begin
			// HiROM save RAM lives at $6000-$7FFF of banks $20-$3F and mirrors
			if (ca[22:21] == 2'b01 && ca[15:13] == 3'b011) begin
				region = snes_cart_pkg::REG_BSRAM;
			end else if (ca[22] || ca[15]) begin
				region = snes_cart_pkg::REG_ROM;
			end
		end
	end

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			s1_region <= snes_cart_pkg::REG_NONE;
			s1_rd     <= 1'b0;
			s1_wr     <= 1'b0;
		end else begin
			s1_region <= region;
			s1_rd     <= !cpurd_n;
			s1_wr     <= !cpuwr_n;
		end
	end

	always_ff @(posedge mclk) begin
		s1_ca    <= ca;
		s1_wdata <= cpu_dout;
	end

	// The CPU never drives both strobes in one cycle
	a_strobe_excl: assert property (@(posedge mclk) disable iff (!rst_n)
		cpurd_n || cpuwr_n)
		else $error("bus_decode: read and write strobes low together");

endmodule

// File: source/cart_map.sv
`timescale 1ns/1ps

module cart_map #(
	parameter int ROM_AW   = snes_cart_pkg::ROM_AW,
	parameter int BSRAM_AW = snes_cart_pkg::BSRAM_AW
) (
	input  logic                                mclk,
	input  logic                                rst_n,
	input  snes_cart_pkg::map_mode_t            map_mode,
	input  logic [ROM_AW-1:0]                   rom_mask,
	input  logic [BSRAM_AW-1:0]                 ram_mask,
	input  logic [snes_cart_pkg::CPU_AW-1:0]    s1_ca,
	input  snes_cart_pkg::region_t              s1_region,
	input  logic                                s1_rd,
	input  logic                                s1_wr,
	input  logic [snes_cart_pkg::DATA_W-1:0]    s1_wdata,
	output logic [ROM_AW-1:0]                   rom_addr,
	output logic                                rom_ce_n,
	output logic                                rom_oe_n,
	output logic [BSRAM_AW-1:0]                 bsram_addr,
	output logic [snes_cart_pkg::DATA_W-1:0]    bsram_d,
	output logic                                bsram_ce_n,
	output logic                                bsram_oe_n,
	output logic                                bsram_we_n,
	output snes_cart_pkg::region_t              s2_region,
	output logic                                s2_rd,
	output logic                                s2_rom_hi
);

	logic [snes_cart_pkg::CPU_AW-1:0] rom_full;
	logic [snes_cart_pkg::CPU_AW-1:0] ram_full;
	logic [ROM_AW-1:0]                rom_masked;
	logic                             is_rom;
	logic                             is_ram;

	// LoROM drops A15 from the address, HiROM keeps the whole bank linear
	always_comb begin
		if (map_mode == snes_cart_pkg::MAP_HIROM) begin
			rom_full = {2'b00, s1_ca[21:0]};
			ram_full = {6'd0, s1_ca[20:16], s1_ca[12:0]};
		end else begin
			rom_full = {2'b00, s1_ca[22:16], s1_ca[14:0]};
			ram_full = {5'd0, s1_ca[19:16], s1_ca[14:0]};
		end
	end

	assign rom_masked = rom_full[ROM_AW-1:0] & rom_mask;
	assign is_rom     = s1_region == snes_cart_pkg::REG_ROM && s1_rd;
	assign is_ram     = s1_region == snes_cart_pkg::REG_BSRAM;

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			rom_ce_n   <= 1'b1;
			rom_oe_n   <= 1'b1;
			bsram_ce_n <= 1'b1;
			bsram_oe_n <= 1'b1;
			bsram_we_n <= 1'b1;
			s2_region  <= snes_cart_pkg::REG_NONE;
			s2_rd      <= 1'b0;
		end else begin
			rom_ce_n   <= !is_rom;
			rom_oe_n   <= !is_rom;
			bsram_ce_n <= !is_ram;
			bsram_oe_n <= !(is_ram && s1_rd);
			bsram_we_n <= !(is_ram && s1_wr);
			s2_region  <= s1_region;
			s2_rd      <= s1_rd;
		end
	end

	always_ff @(posedge mclk) begin
		rom_addr   <= rom_masked;
		bsram_addr <= ram_full[BSRAM_AW-1:0] & ram_mask;
		bsram_d    <= s1_wdata;
		s2_rom_hi  <= rom_masked[0];
	end

	// A decoded access is a read or a write, never both
	a_one_cmd: assert property (@(posedge mclk) disable iff (!rst_n)
		!(s1_rd && s1_wr))
		else $error("cart_map: read and write decoded together");

endmodule

// File: source/cart_top.sv
`timescale 1ns/1ps

module cart_top #(
	parameter int ROM_AW   = snes_cart_pkg::ROM_AW,
	parameter int BSRAM_AW = snes_cart_pkg::BSRAM_AW
) (
	input  logic                                mclk,
	input  logic                                rst_n,
	input  snes_cart_pkg::map_mode_t            map_mode,
	input  logic                                msu_enable,
	input  logic [ROM_AW-1:0]                   rom_mask,
	input  logic [BSRAM_AW-1:0]                 ram_mask,
	input  logic [snes_cart_pkg::CPU_AW-1:0]    ca,
	input  logic                                cpurd_n,
	input  logic                                cpuwr_n,
	input  logic [snes_cart_pkg::DATA_W-1:0]    cpu_dout,
	output logic [snes_cart_pkg::DATA_W-1:0]    cpu_din,
	output logic [ROM_AW-1:0]                   rom_addr,
	input  logic [15:0]                         rom_q,
	output logic                                rom_ce_n,
	output logic                                rom_oe_n,
	output logic [BSRAM_AW-1:0]                 bsram_addr,
	output logic [snes_cart_pkg::DATA_W-1:0]    bsram_d,
	input  logic [snes_cart_pkg::DATA_W-1:0]    bsram_q,
	output logic                                bsram_ce_n,
	output logic                                bsram_oe_n,
	output logic                                bsram_we_n,
	output logic [15:0]                         msu_track_num,
	output logic                                msu_track_request,
	input  logic                                msu_track_missing,
	output logic [7:0]                          msu_volume,
	output logic                                msu_audio_playing,
	output logic                                msu_audio_repeat
);

	logic [snes_cart_pkg::CPU_AW-1:0] s1_ca;
	snes_cart_pkg::region_t           s1_region;
	logic                             s1_rd;
	logic                             s1_wr;
	logic [snes_cart_pkg::DATA_W-1:0] s1_wdata;
	snes_cart_pkg::region_t           s2_region;
	logic                             s2_rd;
	logic                             s2_rom_hi;
	logic [snes_cart_pkg::DATA_W-1:0] msu_rdata;

	bus_decode u_bus_decode (
		.mclk(mclk), .rst_n(rst_n), .map_mode(map_mode), .msu_enable(msu_enable),
		.ca(ca), .cpurd_n(cpurd_n), .cpuwr_n(cpuwr_n), .cpu_dout(cpu_dout),
		.s1_ca(s1_ca), .s1_region(s1_region), .s1_rd(s1_rd), .s1_wr(s1_wr),
		.s1_wdata(s1_wdata)
	);

	cart_map #(.ROM_AW(ROM_AW), .BSRAM_AW(BSRAM_AW)) u_cart_map (
		.mclk(mclk), .rst_n(rst_n), .map_mode(map_mode),
		.rom_mask(rom_mask), .ram_mask(ram_mask),
		.s1_ca(s1_ca), .s1_region(s1_region), .s1_rd(s1_rd), .s1_wr(s1_wr),
		.s1_wdata(s1_wdata),
		.rom_addr(rom_addr), .rom_ce_n(rom_ce_n), .rom_oe_n(rom_oe_n),
		.bsram_addr(bsram_addr), .bsram_d(bsram_d), .bsram_ce_n(bsram_ce_n),
		.bsram_oe_n(bsram_oe_n), .bsram_we_n(bsram_we_n),
		.s2_region(s2_region), .s2_rd(s2_rd), .s2_rom_hi(s2_rom_hi)
	);

	msu_regs u_msu_regs (
		.mclk(mclk), .rst_n(rst_n),
		.s1_ca(s1_ca), .s1_region(s1_region), .s1_rd(s1_rd), .s1_wr(s1_wr),
		.s1_wdata(s1_wdata), .msu_track_missing(msu_track_missing),
		.msu_rdata(msu_rdata), .msu_track_num(msu_track_num),
		.msu_track_request(msu_track_request), .msu_volume(msu_volume),
		.msu_audio_playing(msu_audio_playing), .msu_audio_repeat(msu_audio_repeat)
	);

	data_return u_data_return (
		.mclk(mclk), .rst_n(rst_n),
		.s2_region(s2_region), .s2_rd(s2_rd), .s2_rom_hi(s2_rom_hi),
		.rom_q(rom_q), .bsram_q(bsram_q), .msu_rdata(msu_rdata),
		.cpu_din(cpu_din)
	);

endmodule

// File: source/data_return.sv
`timescale 1ns/1ps

module data_return (
	input  logic                                mclk,
	input  logic                                rst_n,
	input  snes_cart_pkg::region_t              s2_region,
	input  logic                                s2_rd,
	input  logic                                s2_rom_hi,
	input  logic [15:0]                         rom_q,
	input  logic [snes_cart_pkg::DATA_W-1:0]    bsram_q,
	input  logic [snes_cart_pkg::DATA_W-1:0]    msu_rdata,
	output logic [snes_cart_pkg::DATA_W-1:0]    cpu_din
);

	logic [snes_cart_pkg::DATA_W-1:0] sel_byte;

	// The MSU window is decoded ahead of the cartridge, so it wins
	always_comb begin
		sel_byte = '0;
		if (s2_rd) begin
			case (s2_region)
				snes_cart_pkg::REG_MSU:   sel_byte = msu_rdata;
				snes_cart_pkg::REG_ROM:   sel_byte = s2_rom_hi ? rom_q[15:8] : rom_q[7:0];
				snes_cart_pkg::REG_BSRAM: sel_byte = bsram_q;
				default:                  sel_byte = '0;
			endcase
		end
	end

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			cpu_din <= '0;
		end else begin
			cpu_din <= sel_byte;
		end
	end

endmodule

// File: source/msu_regs.sv
`timescale 1ns/1ps

module msu_regs (
	input  logic                                mclk,
	input  logic                                rst_n,
	input  logic [snes_cart_pkg::CPU_AW-1:0]    s1_ca,
	input  snes_cart_pkg::region_t              s1_region,
	input  logic                                s1_rd,
	input  logic                                s1_wr,
	input  logic [snes_cart_pkg::DATA_W-1:0]    s1_wdata,
	input  logic                                msu_track_missing,
	output logic [snes_cart_pkg::DATA_W-1:0]    msu_rdata,
	output logic [15:0]                         msu_track_num,
	output logic                                msu_track_request,
	output logic [7:0]                          msu_volume,
	output logic                                msu_audio_playing,
	output logic                                msu_audio_repeat
);

	logic [2:0]                       off;
	logic                             msu_wr;
	logic                             msu_rd;
	logic [snes_cart_pkg::DATA_W-1:0] rd_byte;

	assign off    = s1_ca[2:0];
	assign msu_wr = s1_wr && s1_region == snes_cart_pkg::REG_MSU;
	assign msu_rd = s1_rd && s1_region == snes_cart_pkg::REG_MSU;

	// ----------------------------------------
	// Read side
	// ----------------------------------------

	always_comb begin
		case (off)
			3'd0:    rd_byte = {2'b00, msu_audio_repeat, msu_audio_playing,
				msu_track_missing, 3'b000};
			3'd1:    rd_byte = '0;
			default: rd_byte = snes_cart_pkg::MSU_ID[8 * (7 - int'(off)) +: 8];
		endcase
	end

	// ----------------------------------------
	// Write side
	// ----------------------------------------

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			msu_track_num     <= '0;
			msu_track_request <= 1'b0;
			msu_volume        <= '0;
			msu_audio_playing <= 1'b0;
			msu_audio_repeat  <= 1'b0;
			msu_rdata         <= '0;
		end else begin
			msu_track_request <= 1'b0;
			msu_rdata         <= msu_rd ? rd_byte : '0;
			if (msu_wr) begin
				case (off)
					3'd4: msu_track_num[7:0] <= s1_wdata;
					// Writing the high byte starts the track load
					3'd5: begin
						msu_track_num[15:8] <= s1_wdata;
						msu_track_request   <= 1'b1;
					end
					3'd6: msu_volume <= s1_wdata;
					3'd7: begin
						msu_audio_playing <= s1_wdata[0];
						msu_audio_repeat  <= s1_wdata[1];
					end
					default: ;
				endcase
			end
		end
	end

	a_req_pulse: assert property (@(posedge mclk) disable iff (!rst_n)
		msu_track_request |=> !msu_track_request)
		else $error("msu_regs: track request held longer than one cycle");

endmodule

// File: source/snes_cart_pkg.sv
package snes_cart_pkg;

	// CPU bus and memory widths
	localparam int CPU_AW   = 24;
	localparam int ROM_AW   = 24;
	localparam int BSRAM_AW = 20;
	localparam int DATA_W   = 8;

	// Cartridge layout as given by the ROM header
	typedef enum logic {
		MAP_LOROM,
		MAP_HIROM
	} map_mode_t;

	// Target of a single CPU bus cycle
	typedef enum logic [2:0] {
		REG_NONE,
		REG_ROM,
		REG_BSRAM,
		REG_WRAM,
		REG_MSU
	} region_t;

	// ----------------------------------------
	// MSU register window
	// ----------------------------------------

	localparam logic [15:0] MSU_BASE = 16'h2000;

	// First character sits in the top byte and is read back at $2002
	localparam logic [47:0] MSU_ID = "S-MSU1";

endpackage

// File: test/tb_cart_model.svh
`ifndef TB_CART_MODEL_SVH
`define TB_CART_MODEL_SVH

// Region codes of the reference model
localparam int R_NONE  = 0;
localparam int R_ROM   = 1;
localparam int R_BSRAM = 2;
localparam int R_WRAM  = 3;
localparam int R_MSU   = 4;

logic [15:0] m_track = '0;
logic [7:0]  m_vol   = '0;
logic        m_play  = 1'b0;
logic        m_rep   = 1'b0;

function automatic logic [7:0] rom_fill(input logic [ROM_AW-1:0] a);
	return (a[7:0] * 8'd13) ^ a[15:8] ^ 8'ha5;
endfunction

function automatic logic [7:0] bsram_fill(input logic [BSRAM_AW-1:0] a);
	return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
endfunction

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic logic [31:0] next_rand();
	rng = xorshift(rng);
	return rng;
endfunction

function automatic logic [7:0] id_byte(input logic [2:0] off);
	case (off)
		3'd2:    return "S";
		3'd3:    return "-";
		3'd4:    return "M";
		3'd5:    return "S";
		3'd6:    return "U";
		default: return "1";
	endcase
endfunction

function automatic int model_region(input logic active, input logic [23:0] a);
	if (!active)
		return R_NONE;
	if (a[23:17] == 7'h3f)
		return R_WRAM;
	if (cur_msu_en && !a[22] && a[15:0] >= 16'h2000 && a[15:0] <= 16'h2007)
		return R_MSU;
	if (cur_mode == snes_cart_pkg::MAP_LOROM) begin
		if (a[22:20] == 3'b111 && !a[15])
			return R_BSRAM;
		return a[15] ? R_ROM : R_NONE;
	end
	if (a[22:21] == 2'b01 && a[15:0] >= 16'h6000 && a[15:0] <= 16'h7fff)
		return R_BSRAM;
	return (a[22] || a[15]) ? R_ROM : R_NONE;
endfunction

task automatic predict_access(input logic rd, input logic wr, input logic [23:0] a,
	input logic [7:0] d, output exp_t e);
	int                  kind;
	logic [23:0]         rfull;
	logic [23:0]         bfull;
	logic [ROM_AW-1:0]   raddr;
	logic [BSRAM_AW-1:0] baddr;
	kind = model_region(rd || wr, a);
	// Bank bits slide down over the address bits that the layout skips
	if (cur_mode == snes_cart_pkg::MAP_HIROM) begin
		rfull = a & 24'h3fffff;
		bfull = ((a >> 3) & 24'h03e000) | (a & 24'h001fff);
	end else begin
		rfull = ((a >> 1) & 24'h3f8000) | (a & 24'h007fff);
		bfull = ((a >> 1) & 24'h078000) | (a & 24'h007fff);
	end
	raddr = rfull[ROM_AW-1:0] & cur_rom_mask;
	baddr = bfull[BSRAM_AW-1:0] & cur_ram_mask;
	e = '0;
	e.rom_ce_n   = 1'b1;
	e.rom_oe_n   = 1'b1;
	e.bsram_ce_n = 1'b1;
	e.bsram_oe_n = 1'b1;
	e.bsram_we_n = 1'b1;
	e.rom_addr   = raddr;
	e.bsram_addr = baddr;
	e.bsram_d    = d;
	if (kind == R_ROM && rd) begin
		e.rom_ce_n = 1'b0;
		e.rom_oe_n = 1'b0;
		e.din      = rom_mem[raddr];
	end else if (kind == R_BSRAM) begin
		e.bsram_ce_n = 1'b0;
		e.bsram_oe_n = !rd;
		e.bsram_we_n = !wr;
		if (rd)
			e.din = shadow_mem[baddr];
		if (wr)
			shadow_mem[baddr] = d;
	end else if (kind == R_MSU && wr) begin
		case (a[2:0])
			3'd4: m_track[7:0] = d;
			3'd5: begin
				m_track[15:8] = d;
				e.req = 1'b1;
			end
			3'd6: m_vol = d;
			3'd7: begin
				m_play = d[0];
				m_rep  = d[1];
			end
			default: ;
		endcase
	end else if (kind == R_MSU && rd) begin
		if (a[2:0] == 3'd0)
			e.din = (m_rep ? 8'h20 : 8'h00) | (m_play ? 8'h10 : 8'h00)
				| (cur_missing ? 8'h08 : 8'h00);
		else if (a[2:0] != 3'd1)
			e.din = id_byte(a[2:0]);
	end
	e.track = m_track;
	e.vol   = m_vol;
	e.play  = m_play;
	e.rep   = m_rep;
endtask

// ----------------------------------------
// Compare tasks
// ----------------------------------------

task automatic check_strobe(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		err_count++;
		$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		fail_run();
	end
endtask

task automatic check_byte(input string name, input logic [snes_cart_pkg::DATA_W-1:0] got,
	input logic [snes_cart_pkg::DATA_W-1:0] exp);
	if (got !== exp) begin
		err_count++;
		$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		fail_run();
	end
endtask

task automatic check_rom_addr(input logic [ROM_AW-1:0] got, input logic [ROM_AW-1:0] exp);
	if (got !== exp) begin
		err_count++;
		$display("Error at %0t: rom_addr is %h, expected %h", $time, got, exp);
		fail_run();
	end
endtask

task automatic check_bsram_addr(input logic [BSRAM_AW-1:0] got,
	input logic [BSRAM_AW-1:0] exp);
	if (got !== exp) begin
		err_count++;
		$display("Error at %0t: bsram_addr is %h, expected %h", $time, got, exp);
		fail_run();
	end
endtask

task automatic check_track(input logic [15:0] got, input logic [15:0] exp);
	if (got !== exp) begin
		err_count++;
		$display("Error at %0t: msu_track_num is %h, expected %h", $time, got, exp);
		fail_run();
	end
endtask

`endif

// File: test/tb_cart_top.sv
`timescale 1ns/1ps

module tb_cart_top;

	localparam int ROM_AW         = 16;
	localparam int BSRAM_AW       = 12;
	localparam int TIMEOUT_CYCLES = 5000;

	typedef struct packed {
		logic                rom_ce_n;
		logic                rom_oe_n;
		logic                bsram_ce_n;
		logic                bsram_oe_n;
		logic                bsram_we_n;
		logic [ROM_AW-1:0]   rom_addr;
		logic [BSRAM_AW-1:0] bsram_addr;
		logic [7:0]          bsram_d;
		logic                req;
		logic [7:0]          din;
		logic [15:0]         track;
		logic [7:0]          vol;
		logic                play;
		logic                rep;
	} exp_t;

	logic mclk;
	logic rst_n;
	snes_cart_pkg::map_mode_t map_mode;
	logic msu_enable;
	logic [ROM_AW-1:0] rom_mask;
	logic [BSRAM_AW-1:0] ram_mask;
	logic [23:0] ca;
	logic cpurd_n;
	logic cpuwr_n;
	logic [7:0] cpu_dout;
	logic [7:0] cpu_din;
	logic [ROM_AW-1:0] rom_addr;
	logic [15:0] rom_q;
	logic rom_ce_n;
	logic rom_oe_n;
	logic [BSRAM_AW-1:0] bsram_addr;
	logic [7:0] bsram_d;
	logic [7:0] bsram_q;
	logic bsram_ce_n;
	logic bsram_oe_n;
	logic bsram_we_n;
	logic [15:0] msu_track_num;
	logic msu_track_request;
	logic msu_track_missing;
	logic [7:0] msu_volume;
	logic msu_audio_playing;
	logic msu_audio_repeat;

	snes_cart_pkg::map_mode_t cur_mode = snes_cart_pkg::MAP_LOROM;
	logic                     cur_msu_en = 1'b1;
	logic [ROM_AW-1:0]        cur_rom_mask = '1;
	logic [BSRAM_AW-1:0]      cur_ram_mask = '1;
	logic                     cur_missing = 1'b0;

	logic [7:0]  rom_mem [0:2**ROM_AW-1];
	logic [7:0]  bsram_mem [0:2**BSRAM_AW-1];
	logic [7:0]  shadow_mem [0:2**BSRAM_AW-1];
	exp_t        pend [$];
	logic [31:0] rng = 32'd26;
	int          cycles = 0;
	int          err_count = 0;

	task automatic fail_run();
		$display("Done: errors found");
		$fatal(1);
	endtask

	`include "tb_cart_model.svh"

	cart_top #(.ROM_AW(ROM_AW), .BSRAM_AW(BSRAM_AW)) DUT (.*);

	// Memories answer in the same cycle
	assign rom_q   = {rom_mem[{rom_addr[ROM_AW-1:1], 1'b1}],
		rom_mem[{rom_addr[ROM_AW-1:1], 1'b0}]};
	assign bsram_q = bsram_mem[bsram_addr];

	always @(posedge mclk) begin
		if (!bsram_we_n)
			bsram_mem[bsram_addr] <= bsram_d;
	end

	initial begin
		mclk = 1'b0;
		forever #5 mclk = ~mclk;
	end

	always @(posedge mclk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
			fail_run();
		end
	end

	// One bus access per call, checked at N+2 for strobes and N+3 for data
	task automatic bus_cycle(input logic rd, input logic wr, input logic [23:0] a,
		input logic [7:0] d);
		exp_t e;
		exp_t s;
		@(posedge mclk);
		ca                <= a;
		cpurd_n           <= !rd;
		cpuwr_n           <= !wr;
		cpu_dout          <= d;
		map_mode          <= cur_mode;
		msu_enable        <= cur_msu_en;
		rom_mask          <= cur_rom_mask;
		ram_mask          <= cur_ram_mask;
		msu_track_missing <= cur_missing;
		predict_access(rd, wr, a, d, e);
		pend.push_back(e);
		@(negedge mclk);
		if (pend.size() >= 3) begin
			s = pend[pend.size() - 3];
			check_strobe("rom_ce_n", rom_ce_n, s.rom_ce_n);
			check_strobe("rom_oe_n", rom_oe_n, s.rom_oe_n);
			check_strobe("bsram_ce_n", bsram_ce_n, s.bsram_ce_n);
			check_strobe("bsram_oe_n", bsram_oe_n, s.bsram_oe_n);
			check_strobe("bsram_we_n", bsram_we_n, s.bsram_we_n);
			check_strobe("msu_track_request", msu_track_request, s.req);
			check_track(msu_track_num, s.track);
			check_byte("msu_volume", msu_volume, s.vol);
			check_strobe("msu_audio_playing", msu_audio_playing, s.play);
			check_strobe("msu_audio_repeat", msu_audio_repeat, s.rep);
			if (!s.rom_ce_n)
				check_rom_addr(rom_addr, s.rom_addr);
			if (!s.bsram_ce_n)
				check_bsram_addr(bsram_addr, s.bsram_addr);
			if (!s.bsram_we_n)
				check_byte("bsram_d", bsram_d, s.bsram_d);
		end
		if (pend.size() == 4) begin
			check_byte("cpu_din", cpu_din, pend[0].din);
			void'(pend.pop_front());
		end
	endtask

	task automatic drain(input int n);
		repeat (n) bus_cycle(1'b0, 1'b0, 24'h0, 8'h0);
	endtask

	task automatic random_access();
		logic [31:0] r;
		logic [31:0] s;
		logic [23:0] a;
		r = next_rand();
		s = next_rand();
		case (r[26:24])
			3'd0:    a = {7'h3f, r[0], r[15:0]};
			3'd1:    a = {r[23], 1'b0, r[21:16], 13'h0400, r[2:0]};
			3'd2:    a = {r[23], 3'b111, r[19:16], 1'b0, r[14:0]};
			3'd3:    a = {r[23], 2'b01, r[20:16], 3'b011, r[12:0]};
			default: a = r[23:0];
		endcase
		case (s[1:0])
			2'd0, 2'd1: bus_cycle(1'b1, 1'b0, a, s[15:8]);
			2'd2:       bus_cycle(1'b0, 1'b1, a, s[15:8]);
			default:    bus_cycle(1'b0, 1'b0, a, s[15:8]);
		endcase
	endtask

	initial begin
		logic [31:0] r;
		rst_n = 1'b0;
		map_mode = snes_cart_pkg::MAP_LOROM;
		msu_enable = 1'b0;
		rom_mask = '1;
		ram_mask = '1;
		ca = '0;
		cpurd_n = 1'b1;
		cpuwr_n = 1'b1;
		cpu_dout = '0;
		msu_track_missing = 1'b0;
		for (int i = 0; i < 2**ROM_AW; i++)
			rom_mem[i] = rom_fill(i[ROM_AW-1:0]);
		for (int i = 0; i < 2**BSRAM_AW; i++) begin
			bsram_mem[i]  = bsram_fill(i[BSRAM_AW-1:0]);
			shadow_mem[i] = bsram_fill(i[BSRAM_AW-1:0]);
		end
		repeat (8) @(posedge mclk);
		@(negedge mclk);
		check_strobe("rom_ce_n", rom_ce_n, 1'b1);
		check_strobe("rom_oe_n", rom_oe_n, 1'b1);
		check_strobe("bsram_ce_n", bsram_ce_n, 1'b1);
		check_strobe("bsram_oe_n", bsram_oe_n, 1'b1);
		check_strobe("bsram_we_n", bsram_we_n, 1'b1);
		check_strobe("msu_track_request", msu_track_request, 1'b0);
		check_strobe("msu_audio_playing", msu_audio_playing, 1'b0);
		check_strobe("msu_audio_repeat", msu_audio_repeat, 1'b0);
		check_byte("cpu_din", cpu_din, 8'h00);
		check_byte("msu_volume", msu_volume, 8'h00);
		check_track(msu_track_num, 16'h0000);
		@(posedge mclk);
		rst_n <= 1'b1;

		// LoROM reads, then cycles that select nothing
		bus_cycle(1'b1, 1'b0, 24'h008000, 8'h00);
		bus_cycle(1'b1, 1'b0, 24'h80ffff, 8'h00);
		bus_cycle(1'b1, 1'b0, 24'h7e1234, 8'h00);
		bus_cycle(1'b1, 1'b0, 24'h7f8000, 8'h00);
		bus_cycle(1'b1, 1'b0, 24'h001000, 8'h00);
		bus_cycle(1'b0, 1'b1, 24'h7e0000, 8'h11);
		drain(2);

		// MSU window
		bus_cycle(1'b0, 1'b1, 24'h002004, 8'h34);
		bus_cycle(1'b0, 1'b1, 24'h002005, 8'h12);
		bus_cycle(1'b0, 1'b1, 24'h002006, 8'h80);
		bus_cycle(1'b0, 1'b1, 24'h002007, 8'h03);
		for (int i = 0; i < 8; i++)
			bus_cycle(1'b1, 1'b0, 24'h002000 + 24'(i), 8'h00);
		drain(4);
		check_track(msu_track_num, 16'h1234);
		check_byte("msu_volume", msu_volume, 8'h80);
		check_strobe("msu_audio_playing", msu_audio_playing, 1'b1);
		check_strobe("msu_audio_repeat", msu_audio_repeat, 1'b1);
		cur_missing = 1'b1;
		drain(4);
		bus_cycle(1'b1, 1'b0, 24'h002000, 8'h00);
		cur_msu_en = 1'b0;
		bus_cycle(1'b1, 1'b0, 24'h002000, 8'h00);
		bus_cycle(1'b0, 1'b1, 24'h002004, 8'h55);
		drain(4);
		check_track(msu_track_num, 16'h1234);

		// HiROM save RAM write and read back
		cur_mode = snes_cart_pkg::MAP_HIROM;
		cur_msu_en = 1'b1;
		cur_missing = 1'b0;
		drain(4);
		bus_cycle(1'b0, 1'b1, 24'h206000, 8'ha5);
		bus_cycle(1'b0, 1'b1, 24'h3f7fff, 8'h5a);
		bus_cycle(1'b1, 1'b0, 24'h206000, 8'h00);
		bus_cycle(1'b1, 1'b0, 24'h3f7fff, 8'h00);
		bus_cycle(1'b1, 1'b0, 24'hc01235, 8'h00);
		bus_cycle(1'b1, 1'b0, 24'h001000, 8'h00);

		// Random blocks of LoROM, HiROM and then both
		for (int b = 0; b < 20; b++) begin
			// Layout and masks only change while the pipeline holds idle cycles
			drain(4);
			r = next_rand();
			if (b < 7)
				cur_mode = snes_cart_pkg::MAP_LOROM;
			else if (b < 14)
				cur_mode = snes_cart_pkg::MAP_HIROM;
			else
				cur_mode = snes_cart_pkg::map_mode_t'(r[0]);
			cur_msu_en = (b < 14) ? 1'b1 : r[1];
			cur_missing = r[2];
			cur_rom_mask = r[3] ? '1 : r[31:16];
			cur_ram_mask = r[4] ? '1 : r[15:4];
			repeat (100) random_access();
		end
		drain(4);

		if (err_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			fail_run();
		end
	end

endmodule

// File: verilog.f
+incdir+test
source/snes_cart_pkg.sv
source/bus_decode.sv
source/cart_map.sv
source/msu_regs.sv
source/data_return.sv
source/cart_top.sv
test/tb_cart_top.sv
